// File: bench/pe_model.svh
// Reference model and random source for the PE array testbench.
// Included inside the testbench module after the pe_array_pkg import.
// The LFSR is 32-bit Fibonacci, one step per bit taken.
// The model keeps one wrapping signed accumulator per MAC cell.
`ifndef PE_MODEL_SVH
`define PE_MODEL_SVH

// ------------------------------
// random source
// ------------------------------
logic [31:0] lfsr_state;

// x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_step()};
    end
    return v;
endfunction

// ------------------------------
// accumulator model
// ------------------------------
logic signed [ACC_WD-1:0] model_acc [PE_GRP_NUM][PE_OC_NUM][PE_H_NUM][PE_COL_NUM];

function automatic void model_clear();
    for (int g = 0; g < PE_GRP_NUM; g++) begin
        for (int oc = 0; oc < PE_OC_NUM; oc++) begin
            for (int h = 0; h < PE_H_NUM; h++) begin
                for (int c = 0; c < PE_COL_NUM; c++) begin
                    model_acc[g][oc][h][c] = '0;
                end
            end
        end
    end
endfunction

// a cell adds feature * weight only if both its group and its column are valid
function automatic void model_beat(input pe_beat_t b);
    int f;
    int w;
    int p;
    for (int g = 0; g < PE_GRP_NUM; g++) begin
        for (int oc = 0; oc < PE_OC_NUM; oc++) begin
            for (int h = 0; h < PE_H_NUM; h++) begin
                for (int c = 0; c < PE_COL_NUM; c++) begin
                    if (b.grp_vld[g] && b.col_vld[c]) begin
                        f = $signed(b.grp[g].features[h][c]);
                        w = $signed(b.grp[g].weights[oc]);
                        p = f * w;
                        model_acc[g][oc][h][c] = model_acc[g][oc][h][c] + ACC_WD'(p);
                    end
                end
            end
        end
    end
endfunction

`endif

// File: bench/tb_pe_array.sv
`timescale 1ns/1ps
// Random testbench for pe_array_top, checked against an accumulator model.
// Stimulus comes from an LFSR with a fixed seed. The first rows use full
// masks and only -128 or 127 as values, with signs picked so that every
// accumulator passes the 18-bit wrap.
// Outputs and handshakes are sampled on the falling clock edge.
module tb_pe_array;

    import pe_array_pkg::*;

    localparam int ROW_NUM      = 40;
    localparam int EXTREME_ROWS = 4;
    localparam int BEAT_TOTAL   = ROW_NUM * TAP_NUM;
    localparam int CLK_PERIOD   = 100;
    localparam int WATCHDOG_NS  = ROW_NUM * (TAP_NUM + 40) * CLK_PERIOD * 4;

    `include "pe_model.svh"

    logic       clk;
    logic       rstn;
    pe_beat_t   beat;
    logic       beat_valid;
    logic       beat_ready;
    pe_result_t result;
    logic       result_valid;
    logic       result_ready;

    int         beats_sent;
    int         row_beats;      // beats taken in the current row
    int         rows_done;
    int         mismatch_cnt;
    int         proto_err_cnt;
    logic       beat_take;      // beat handshake at the coming edge
    logic       stalled;        // result offered but not taken at the last edge
    logic       cleared;        // result taken at the last edge
    pe_result_t held_result;

    pe_array_top uut (
        .clk          (clk),
        .rstn         (rstn),
        .beat         (beat),
        .beat_valid   (beat_valid),
        .beat_ready   (beat_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------
    // stimulus
    // ------------------------------
    function automatic pe_beat_t make_beat(input logic extreme);
        pe_beat_t b;
        logic     s;   // sign of one extreme beat
        s = lfsr_step();
        for (int g = 0; g < PE_GRP_NUM; g++) begin
            for (int h = 0; h < PE_H_NUM; h++) begin
                for (int c = 0; c < PE_COL_NUM; c++) begin
                    if (extreme) begin
                        b.grp[g].features[h][c] = s ? 8'h80 : 8'h7f;
                    end else begin
                        b.grp[g].features[h][c] = FEATURE_WD'(take_bits(FEATURE_WD));
                    end
                end
            end
            for (int oc = 0; oc < PE_OC_NUM; oc++) begin
                if (extreme) begin
                    // oc 0 products stay positive, oc 1 products negative
                    b.grp[g].weights[oc] = (s ^ oc[0]) ? 8'h80 : 8'h7f;
                end else begin
                    b.grp[g].weights[oc] = WEIGHT_WD'(take_bits(WEIGHT_WD));
                end
            end
        end
        b.col_vld = extreme ? '1 : PE_COL_NUM'(take_bits(PE_COL_NUM));
        b.grp_vld = extreme ? '1 : PE_GRP_NUM'(take_bits(PE_GRP_NUM));
        return b;
    endfunction

    always @(posedge clk) begin
        if (rstn) begin
            if (!beat_valid || beat_take) begin
                // about one slot in four left empty
                if (beats_sent < BEAT_TOTAL && take_bits(2) != 0) begin
                    beat       <= make_beat(beats_sent / TAP_NUM < EXTREME_ROWS);
                    beat_valid <= 1'b1;
                    beats_sent <= beats_sent + 1;
                end else begin
                    beat_valid <= 1'b0;
                end
            end
            result_ready <= (take_bits(2) != 0);   // random stalls
        end
    end

    // ------------------------------
    // monitor and checks
    // ------------------------------
    task automatic check_result();
        for (int g = 0; g < PE_GRP_NUM; g++) begin
            for (int oc = 0; oc < PE_OC_NUM; oc++) begin
                for (int h = 0; h < PE_H_NUM; h++) begin
                    for (int c = 0; c < PE_COL_NUM; c++) begin
                        if (result[g][oc][h][c] !== model_acc[g][oc][h][c]) begin
                            mismatch_cnt++;
                            $display("MISMATCH %0t: row %0d cell %0d.%0d.%0d.%0d got %0d exp %0d",
                                     $time, rows_done, g, oc, h, c,
                                     $signed(result[g][oc][h][c]), model_acc[g][oc][h][c]);
                        end
                    end
                end
            end
        end
    endtask

    always @(negedge clk) begin
        if (rstn) begin
            if (beat_ready === result_valid) begin
                proto_err_cnt++;
                $display("%0t: beat_ready and result_valid are both %b", $time, beat_ready);
            end
            if (result_valid !== (row_beats == TAP_NUM)) begin
                mismatch_cnt++;
                $display("MISMATCH %0t: result_valid is %b after %0d beats of the row",
                         $time, result_valid, row_beats);
            end
            if (stalled && result !== held_result) begin
                mismatch_cnt++;
                $display("MISMATCH %0t: result changed while it was not taken", $time);
            end
            if (cleared && result !== '0) begin
                mismatch_cnt++;
                $display("MISMATCH %0t: accumulators not zero after result handshake", $time);
            end

            if (result_valid && result_ready) begin
                check_result();
            end

            beat_take = beat_valid && beat_ready;
            if (beat_take) begin
                model_beat(beat);
                row_beats++;
            end
            stalled     = result_valid && !result_ready;
            cleared     = result_valid && result_ready;
            held_result = result;
            if (cleared) begin
                model_clear();
                row_beats = 0;
                rows_done++;
            end
        end
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        clk           = 1'b0;
        rstn          = 1'b0;
        beat          = '0;
        beat_valid    = 1'b0;
        result_ready  = 1'b0;
        lfsr_state    = 32'h72a4_4903;
        beats_sent    = 0;
        row_beats     = 0;
        rows_done     = 0;
        mismatch_cnt  = 0;
        proto_err_cnt = 0;
        beat_take     = 1'b0;
        stalled       = 1'b0;
        cleared       = 1'b0;
        held_result   = '0;
        model_clear();

        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        if (result_valid !== 1'b0 || beat_ready !== 1'b1) begin
            proto_err_cnt++;
            $display("%0t: handshake outputs wrong after reset", $time);
        end

        while (rows_done < ROW_NUM) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);

        $display("errors: %0d mismatches, %0d protocol", mismatch_cnt, proto_err_cnt);
        if (mismatch_cnt + proto_err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("%0t: run timed out with %0d of %0d rows taken", $time, rows_done, ROW_NUM);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: rtl/pe_array_pkg.sv
// Sizes and bus layouts of the convolution PE array.
// Features and weights are two's complement.
// Accumulators wrap modulo 2**ACC_WD and do not saturate.
// ACC_WD must be at least PROD_WD, and TAP_CNT_WD must hold TAP_NUM-1.
package pe_array_pkg;

    // ------------------------------
    // data widths
    // ------------------------------
    localparam int FEATURE_WD = 8;
    localparam int WEIGHT_WD  = 8;
    localparam int PROD_WD    = FEATURE_WD + WEIGHT_WD;   // full signed product
    localparam int ACC_WD     = 18;

    // ------------------------------
    // array shape
    // ------------------------------
    localparam int PE_COL_NUM = 4;
    localparam int PE_H_NUM   = 2;    // feature rows per group
    localparam int PE_OC_NUM  = 2;
    localparam int PE_GRP_NUM = 2;    // input-channel groups

    // KxK taps per output row
    localparam int TAP_NUM    = 9;
    localparam int TAP_CNT_WD = 4;

    // ------------------------------
    // beat in
    // ------------------------------
    // one input-channel group, 80 bits
    typedef struct packed {
        logic [PE_H_NUM-1:0][PE_COL_NUM-1:0][FEATURE_WD-1:0] features; // fan out to every oc
        logic [PE_OC_NUM-1:0][WEIGHT_WD-1:0]                 weights;  // fan out to every h
    } grp_in_t;

    // 166 bits
    typedef struct packed {
        grp_in_t [PE_GRP_NUM-1:0] grp;
        logic    [PE_COL_NUM-1:0] col_vld;
        logic    [PE_GRP_NUM-1:0] grp_vld;
    } pe_beat_t;

    // ------------------------------
    // result out
    // ------------------------------
    typedef logic [PE_COL_NUM-1:0][ACC_WD-1:0] row_acc_t;          // 72 bits

    // indexed [oc][h]
    typedef row_acc_t [PE_OC_NUM-1:0][PE_H_NUM-1:0] grp_acc_t;     // 288 bits

    typedef grp_acc_t [PE_GRP_NUM-1:0] pe_result_t;                // 576 bits

endpackage

// File: rtl/pe_array_top.sv
`timescale 1ns/1ps
// Top of the convolution PE array, 2 groups x 2 oc x 2 h x 4 columns.
// A row takes TAP_NUM accepted beats; the result is then held and
// beat_ready stays low until result_ready.
// Accumulators clear on the result handshake.
// beat_valid must not drop while beat_ready is low.
module pe_array_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  pe_array_pkg::pe_beat_t   beat,
    input  logic                     beat_valid,
    output logic                     beat_ready,
    output pe_array_pkg::pe_result_t result,
    output logic                     result_valid,
    input  logic                     result_ready
);

    import pe_array_pkg::*;

    logic beat_fire;
    logic acc_clr;
    logic row_done;

    // ------------------------------
    // control
    // ------------------------------
    pe_ctrl_fsm u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .beat_valid   (beat_valid),
        .row_done     (row_done),
        .result_ready (result_ready),
        .beat_ready   (beat_ready),
        .result_valid (result_valid),
        .beat_fire    (beat_fire),
        .acc_clr      (acc_clr)
    );

    tap_counter u_tap (
        .clk       (clk),
        .rstn      (rstn),
        .beat_fire (beat_fire),
        .row_done  (row_done)
    );

    // ------------------------------
    // input-channel groups
    // ------------------------------
    for (genvar g = 0; g < PE_GRP_NUM; g++) begin : g_grp
        pe_ic_group u_grp (
            .clk       (clk),
            .rstn      (rstn),
            .beat_fire (beat_fire),
            .acc_clr   (acc_clr),
            .grp_vld   (beat.grp_vld[g]),
            .grp_in    (beat.grp[g]),
            .col_vld   (beat.col_vld),   // same column mask for all groups
            .grp_acc   (result[g])
        );
    end

endmodule

// File: rtl/pe_ctrl_fsm.sv
`timescale 1ns/1ps
// Accumulate/done control of the PE array.
// beat_ready is low for the whole done state, so a finished row is held
// until the post-processing unit takes it.
// row_done must only pulse together with beat_fire.
module pe_ctrl_fsm (
    input  logic clk,
    input  logic rstn,
    input  logic beat_valid,
    input  logic row_done,
    input  logic result_ready,
    output logic beat_ready,
    output logic result_valid,
    output logic beat_fire,
    output logic acc_clr
);

    typedef enum logic {
        ACCUM   = 1'b0,
        PE_DONE = 1'b1
    } state_e;

    state_e state;
    state_e state_nxt;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ACCUM;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ACCUM: begin
                if (row_done) state_nxt = PE_DONE;   // last tap taken
            end
            PE_DONE: begin
                if (result_ready) state_nxt = ACCUM;
            end
            default: state_nxt = ACCUM;
        endcase
    end

    assign beat_ready   = (state == ACCUM);
    assign result_valid = (state == PE_DONE);
    assign beat_fire    = beat_valid & beat_ready;
    assign acc_clr      = result_valid & result_ready;   // clear on result handshake

    // scheduler keeps a stalled beat offered
    a_beat_hold: assert property (@(posedge clk) disable iff (!rstn)
        beat_valid && !beat_ready |=> beat_valid);

    // result stays offered until taken
    a_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
        result_valid && !result_ready |=> result_valid);

endmodule

// File: rtl/pe_ic_group.sv
`timescale 1ns/1ps
// All PE rows of one input-channel group.
// Each feature row feeds every output channel, and each output-channel
// weight feeds every feature row.
// grp_vld enables the whole group; col_vld masks columns in every row.
module pe_ic_group (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                beat_fire,
    input  logic                                acc_clr,
    input  logic                                grp_vld,
    input  pe_array_pkg::grp_in_t               grp_in,
    input  logic [pe_array_pkg::PE_COL_NUM-1:0] col_vld,
    output pe_array_pkg::grp_acc_t              grp_acc
);

    import pe_array_pkg::*;

    // ------------------------------
    // oc x h grid of rows
    // ------------------------------
    for (genvar oc = 0; oc < PE_OC_NUM; oc++) begin : g_oc
        for (genvar h = 0; h < PE_H_NUM; h++) begin : g_h
            pe_row u_row (
                .clk       (clk),
                .rstn      (rstn),
                .beat_fire (beat_fire),
                .acc_clr   (acc_clr),
                .en        (grp_vld),
                .features  (grp_in.features[h]),   // shared across oc
                .weight    (grp_in.weights[oc]),   // shared across h
                .col_vld   (col_vld),
                .acc       (grp_acc[oc][h])
            );
        end
    end

endmodule

// File: rtl/pe_row.sv
`timescale 1ns/1ps
// One row of MAC cells for one output channel and one feature row.
// All columns share the same weight.
// Products are sign extended and added with wrap at ACC_WD bits.
// acc_clr wins over an update but never meets beat_fire in practice.
module pe_row (
    input  logic                                                         clk,
    input  logic                                                         rstn,
    input  logic                                                         beat_fire,
    input  logic                                                         acc_clr,
    input  logic                                                         en,
    input  logic [pe_array_pkg::PE_COL_NUM-1:0][pe_array_pkg::FEATURE_WD-1:0] features,
    input  logic [pe_array_pkg::WEIGHT_WD-1:0]                          weight,
    input  logic [pe_array_pkg::PE_COL_NUM-1:0]                         col_vld,
    output pe_array_pkg::row_acc_t                                      acc
);

    import pe_array_pkg::*;

    row_acc_t prod_ext;   // products widened to accumulator width

    // ------------------------------
    // multipliers
    // ------------------------------
    for (genvar c = 0; c < PE_COL_NUM; c++) begin : g_mul
        logic signed [PROD_WD-1:0] prod;

        assign prod        = $signed(features[c]) * $signed(weight);
        assign prod_ext[c] = {{(ACC_WD - PROD_WD){prod[PROD_WD-1]}}, prod};
    end

    // ------------------------------
    // accumulators
    // ------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc <= '0;
        end else if (acc_clr) begin
            acc <= '0;
        end else if (beat_fire && en) begin
            for (int c = 0; c < PE_COL_NUM; c++) begin
                if (col_vld[c]) begin
                    acc[c] <= acc[c] + prod_ext[c];   // wraps
                end
            end
        end
    end

endmodule

// File: rtl/tap_counter.sv
`timescale 1ns/1ps
// Counts accepted beats of one output row.
// row_done is combinational and marks the beat that completes the row;
// the count wraps to zero on that same beat.
module tap_counter (
    input  logic clk,
    input  logic rstn,
    input  logic beat_fire,
    output logic row_done
);

    import pe_array_pkg::*;

    logic [TAP_CNT_WD-1:0] tap_cnt;
    logic                  last_tap;

    assign last_tap = (tap_cnt == TAP_CNT_WD'(TAP_NUM - 1));
    assign row_done = beat_fire & last_tap;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tap_cnt <= '0;
        end else if (beat_fire) begin
            if (last_tap) begin
                tap_cnt <= '0;
            end else begin
                tap_cnt <= tap_cnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // checks
    // ------------------------------
    a_cnt_range: assert property (@(posedge clk) disable iff (!rstn)
        tap_cnt <= TAP_CNT_WD'(TAP_NUM - 1));

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds and runs tb_pe_array with Verilator.
# Exits non-zero if the build fails, the run fails,
# or the pass message is missing from the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_pe_array -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi

// File: sim.f
+incdir+bench
rtl/pe_array_pkg.sv
rtl/pe_ctrl_fsm.sv
rtl/tap_counter.sv
rtl/pe_row.sv
rtl/pe_ic_group.sv
rtl/pe_array_top.sv
bench/tb_pe_array.sv
